// File: hdl/snd_cfg.svh
// Sound subsystem configuration macros
// Bus widths, FIFO depth, phrase size, sample rate and ADPCM step limits
`ifndef SND_CFG_SVH
`define SND_CFG_SVH

// Sample ROM address width
`define SND_ROM_AW       18
// Signed PCM sample width
`define SND_PCM_W        12
// Sample FIFO entries
`define SND_FIFO_DEPTH   8
// Bytes per phrase, also the phrase stride in ROM
`define SND_PHRASE_BYTES 16
// Clock cycles between sample enables
`define SND_SAMPLE_DIV   12
// Step size at phrase start
`define SND_STEP_INIT    4
// Step size ceiling
`define SND_STEP_MAX     64

`endif

// File: hdl/snd_audio_pkg.sv
// Audio side types
// PCM sample, ADPCM code, step size and fetch FSM states
`default_nettype none
`include "snd_cfg.svh"

package snd_audio_pkg;

    // Signed PCM level
    typedef logic signed [`SND_PCM_W-1:0] pcm_t;

    // Sign in bit 3 and magnitude in bits 2..0
    typedef logic [3:0] adpcm_code_t;

    // Wide enough to hold the step ceiling
    typedef logic [$clog2(`SND_STEP_MAX + 1)-1:0] step_t;

    // Fetch FSM
    // Two decode states, one per nibble of the ROM byte
    typedef enum logic [2:0] {
        idle,
        request,
        wait_data,
        decode_hi,
        decode_lo
    } fetch_state_e;

endpackage

`default_nettype wire

// File: hdl/snd_rom_pkg.sv
// Sample ROM bus types and sound latch command
`default_nettype none
`include "snd_cfg.svh"

package snd_rom_pkg;

    // Byte address into the sample ROM
    typedef logic [`SND_ROM_AW-1:0] rom_addr_t;

    // One ROM byte, two ADPCM codes
    typedef logic [7:0] rom_byte_t;

    // Latch command, zero stops and n plays phrase n
    typedef logic [7:0] snd_cmd_t;

    // Request side of the ROM bus
    typedef struct packed {
        logic      cs;
        rom_addr_t addr;
    } rom_req_t;

endpackage

`default_nettype wire

// File: hdl/adpcm_fetch.sv
// ADPCM phrase fetch and decode
// ROM byte requests, nibble decode with step adaptation, FIFO push
`timescale 1ns/1ps
`default_nettype none
`include "snd_cfg.svh"

module adpcm_fetch
    import snd_audio_pkg::*, snd_rom_pkg::*;
(
    input  wire            clk,
    input  wire            arst_n,
    // Sound latch from main CPU
    input  wire snd_cmd_t  snd_latch,
    input  wire            snd_latch_wr,
    // Sample ROM
    output rom_req_t       rom_req,
    input  wire rom_byte_t rom_data,
    input  wire            rom_ok,
    // Sample FIFO write side
    input  wire            full,
    output logic           push,
    output pcm_t           push_data,
    output logic           flush
);

    localparam int    PHRASE_BYTES = `SND_PHRASE_BYTES;
    localparam int    CNT_W        = $clog2(PHRASE_BYTES);
    localparam int    SUM_W        = `SND_PCM_W + 2;
    localparam pcm_t  PCM_MAX      = pcm_t'({1'b0, {(`SND_PCM_W - 1){1'b1}}});
    localparam pcm_t  PCM_MIN      = pcm_t'({1'b1, {(`SND_PCM_W - 1){1'b0}}});
    localparam step_t STEP_INIT    = step_t'(`SND_STEP_INIT);
    localparam step_t STEP_MAX     = step_t'(`SND_STEP_MAX);

    fetch_state_e            state;
    logic                    cs;
    rom_addr_t               addr;
    logic [CNT_W-1:0]        byte_cnt;
    rom_byte_t               data_q;
    pcm_t                    sample_q;
    step_t                   step_q;

    logic                    decoding;
    adpcm_code_t             code;
    logic [2:0]              mag;
    logic [9:0]              diff;
    logic signed [SUM_W-1:0] sum;
    logic [7:0]              step_x2;
    step_t                   step_nxt;

    assign rom_req = '{cs: cs, addr: addr};

    // Every latch write empties the FIFO, stop or restart
    assign flush = snd_latch_wr;

    // Push straight from the decoder, stalled by a full FIFO
    assign decoding = (state == decode_hi) || (state == decode_lo);
    assign push     = decoding && !full;

    // High nibble first
    assign code = (state == decode_hi) ? data_q[7:4] : data_q[3:0];
    assign mag  = code[2:0];

    // Step times magnitude, 448 at most
    assign diff = 10'(step_q) * 10'(mag);
    assign sum  = code[3] ? SUM_W'(sample_q) - SUM_W'(diff)
                          : SUM_W'(sample_q) + SUM_W'(diff);

    // Saturate to the PCM range
    always_comb begin
        if (sum > SUM_W'(PCM_MAX)) begin
            push_data = PCM_MAX;
        end else if (sum < SUM_W'(PCM_MIN)) begin
            push_data = PCM_MIN;
        end else begin
            push_data = pcm_t'(sum);
        end
    end

    // Step adaptation
    // Large codes double the step, small ones halve it
    assign step_x2 = {1'b0, step_q} << 1;

    always_comb begin
        step_nxt = step_q;
        if (mag >= 3'd6) begin
            step_nxt = (step_x2 > 8'(STEP_MAX)) ? STEP_MAX : step_t'(step_x2);
        end else if (mag <= 3'd1) begin
            step_nxt = (step_q > step_t'(1)) ? step_q >> 1 : step_t'(1);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= idle;
            cs       <= 1'b0;
            addr     <= '0;
            byte_cnt <= '0;
            sample_q <= '0;
            step_q   <= STEP_INIT;
        end else if (snd_latch_wr) begin
            // Phrase n starts at n times the stride
            cs       <= 1'b0;
            addr     <= rom_addr_t'(snd_latch) * rom_addr_t'(PHRASE_BYTES);
            byte_cnt <= '0;
            sample_q <= '0;
            step_q   <= STEP_INIT;
            state    <= (snd_latch != '0) ? request : idle;
        end else begin
            case (state)
                request: begin
                    cs    <= 1'b1;
                    state <= wait_data;
                end
                wait_data: begin
                    // Hold cs and addr until the ROM answers
                    if (cs && rom_ok) begin
                        cs    <= 1'b0;
                        state <= decode_hi;
                    end
                end
                decode_hi: begin
                    if (!full) begin
                        sample_q <= push_data;
                        step_q   <= step_nxt;
                        state    <= decode_lo;
                    end
                end
                decode_lo: begin
                    if (!full) begin
                        sample_q <= push_data;
                        step_q   <= step_nxt;
                        // Last byte of the phrase
                        if (byte_cnt == CNT_W'(PHRASE_BYTES - 1)) begin
                            state <= idle;
                        end else begin
                            addr     <= addr + 1'b1;
                            byte_cnt <= byte_cnt + 1'b1;
                            state    <= request;
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // ROM byte, taken when cs and rom_ok meet
    always_ff @(posedge clk) begin
        if (state == wait_data && cs && rom_ok) begin
            data_q <= rom_data;
        end
    end

    // ROM address held for the whole pending request
    a_addr_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (rom_req.cs && !rom_ok && !snd_latch_wr) |=> $stable(rom_req.addr));

endmodule

`default_nettype wire

// File: hdl/pcm_fifo.sv
// Synchronous PCM sample FIFO
// Circular buffer with count, single-cycle flush and occupancy checks
`timescale 1ns/1ps
`default_nettype none
`include "snd_cfg.svh"

module pcm_fifo
    import snd_audio_pkg::*;
(
    input  wire       clk,
    input  wire       arst_n,
    // Write side
    input  wire       push,
    input  wire pcm_t push_data,
    // Read side
    input  wire       pop,
    output pcm_t      pop_data,
    // Control and status
    input  wire       flush,
    output logic      full,
    output logic      empty
);

    localparam int DEPTH = `SND_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    pcm_t             mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // Guard against overrun and underrun
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Head of queue, one cycle after the push
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            // Flush wins over push and pop
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Producer must respect full, consumer must respect empty
    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        !(push && full));
    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
        !(pop && empty));

endmodule

`default_nettype wire

// File: hdl/pcm_out.sv
// PCM output stage
// Sample-rate divider, FIFO pop and held output level
`timescale 1ns/1ps
`default_nettype none
`include "snd_cfg.svh"

module pcm_out
    import snd_audio_pkg::*;
(
    input  wire       clk,
    input  wire       arst_n,
    // FIFO read side
    input  wire       empty,
    output logic      pop,
    input  wire pcm_t pop_data,
    input  wire       flush,
    // Audio output
    output pcm_t      pcm,
    output logic      sample
);

    localparam int DIV   = `SND_SAMPLE_DIV;
    localparam int DIV_W = $clog2(DIV);

    logic [DIV_W-1:0] div_cnt;
    logic             cen;

    // Sample enable once every DIV cycles
    assign cen = (div_cnt == DIV_W'(DIV - 1));

    // No pop on an empty FIFO or during flush
    assign pop = cen && !empty && !flush;

    // Free-running divider
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
        end else if (cen) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Level held between samples and on underrun
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pcm    <= '0;
            sample <= 1'b0;
        end else if (flush) begin
            pcm    <= '0;
            sample <= 1'b0;
        end else begin
            sample <= pop;
            if (pop) begin
                pcm <= pop_data;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/snd_adpcm_top.sv
// ADPCM sample playback top level
// Fetch/decode, sample FIFO and output stage
`timescale 1ns/1ps
`default_nettype none

module snd_adpcm_top
    import snd_audio_pkg::*, snd_rom_pkg::*;
(
    input  wire            clk,
    input  wire            arst_n,
    // Sound latch from main CPU
    input  wire snd_cmd_t  snd_latch,
    input  wire            snd_latch_wr,
    // Sample ROM
    output rom_req_t       rom_req,
    input  wire rom_byte_t rom_data,
    input  wire            rom_ok,
    // Sound output
    output pcm_t           pcm,
    output logic           sample
);

    // Decoder to FIFO
    logic push;
    pcm_t push_data;
    logic flush;
    logic full;
    // FIFO to output stage
    logic empty;
    logic pop;
    pcm_t pop_data;

    adpcm_fetch u_fetch (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .snd_latch    ( snd_latch    ),
        .snd_latch_wr ( snd_latch_wr ),
        .rom_req      ( rom_req      ),
        .rom_data     ( rom_data     ),
        .rom_ok       ( rom_ok       ),
        .full         ( full         ),
        .push         ( push         ),
        .push_data    ( push_data    ),
        .flush        ( flush        )
    );

    pcm_fifo u_fifo (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .push      ( push      ),
        .push_data ( push_data ),
        .pop       ( pop       ),
        .pop_data  ( pop_data  ),
        .flush     ( flush     ),
        .full      ( full      ),
        .empty     ( empty     )
    );

    pcm_out u_out (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .empty    ( empty    ),
        .pop      ( pop      ),
        .pop_data ( pop_data ),
        .flush    ( flush    ),
        .pcm      ( pcm      ),
        .sample   ( sample   )
    );

endmodule

`default_nettype wire

// File: verif/snd_rom_model.sv
// Behavioral sample ROM
// Byte array with a data-ready flag after a variable delay
`timescale 1ns/1ps
`default_nettype none

module snd_rom_model
    import snd_rom_pkg::*;
#(
    // Random delay range in normal mode
    parameter int MAX_DELAY  = 5,
    // Fixed delay in slow mode, longer than two sample periods
    parameter int SLOW_DELAY = 30,
    parameter int AW         = 12
)(
    input  wire           clk,
    input  wire           arst_n,
    // Request from the fetch unit
    input  wire rom_req_t rom_req,
    // Slow mode select
    input  wire           slow,
    output rom_byte_t     rom_data,
    output logic          rom_ok
);

    // Covers phrases 0 to 255
    rom_byte_t mem [1 << AW];

    logic busy;
    int   wait_cnt;

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            wait_cnt <= 0;
            rom_ok   <= 1'b0;
            rom_data <= '0;
        end else if (!rom_req.cs || rom_ok) begin
            // Request withdrawn or just answered
            busy   <= 1'b0;
            rom_ok <= 1'b0;
        end else if (!busy) begin
            // New request, draw its latency
            busy     <= 1'b1;
            wait_cnt <= slow ? SLOW_DELAY : int'($urandom_range(MAX_DELAY, 0));
        end else if (wait_cnt > 0) begin
            wait_cnt <= wait_cnt - 1;
        end else begin
            rom_ok   <= 1'b1;
            rom_data <= mem[rom_req.addr[AW-1:0]];
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_snd_adpcm.sv
// Testbench for the ADPCM playback subsystem
// Stimulus, reference decoder, compare process, checks and timeout
`timescale 1ns/1ps
`default_nettype none
`include "snd_cfg.svh"

module tb_snd_adpcm
    import snd_audio_pkg::*, snd_rom_pkg::*;
();

    localparam int CLK_HALF     = 50;
    localparam int DIV          = `SND_SAMPLE_DIV;
    localparam int PHRASE_BYTES = `SND_PHRASE_BYTES;
    localparam int PHRASE_LEN   = 2 * PHRASE_BYTES;
    localparam int NUM_TESTS    = 6;
    localparam int TIMEOUT      = NUM_TESTS * 40 * DIV * 2;
    localparam int IMG_AW       = 12;
    localparam int SETTLE       = 4 * DIV;

    logic      clk;
    logic      arst_n;
    snd_cmd_t  snd_latch;
    logic      snd_latch_wr;
    rom_req_t  rom_req;
    rom_byte_t rom_data;
    logic      rom_ok;
    pcm_t      pcm;
    logic      sample;
    logic      rom_slow;

    // Expected PCM values, oldest first
    int        exp_q [$];
    int        pulse_cnt     = 0;
    int        pulse_base    = 0;
    int        errors        = 0;
    int        errs_at_start = 0;
    int        failed_tests  = 0;
    int        cycle_cnt     = 0;
    string     test_name     = "none";

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    snd_adpcm_top i_dut (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .snd_latch    ( snd_latch    ),
        .snd_latch_wr ( snd_latch_wr ),
        .rom_req      ( rom_req      ),
        .rom_data     ( rom_data     ),
        .rom_ok       ( rom_ok       ),
        .pcm          ( pcm          ),
        .sample       ( sample       )
    );

    snd_rom_model #(.AW(IMG_AW)) i_rom (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .rom_req  ( rom_req  ),
        .slow     ( rom_slow ),
        .rom_data ( rom_data ),
        .rom_ok   ( rom_ok   )
    );

    task automatic check_value(input string what, input int expected, input int actual);
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s: %s expected %0d actual %0d",
                     test_name, what, expected, actual);
        end
    endtask

    // Sample idx of phrase n, decoded from the start of the phrase
    function automatic int ref_decode(input int phrase, input int idx);
        int        acc;
        int        step;
        int        code;
        int        m;
        int        n;
        rom_byte_t b;
        acc  = 0;
        step = `SND_STEP_INIT;
        for (n = 0; n <= idx; n++) begin
            b    = i_rom.mem[IMG_AW'(phrase * PHRASE_BYTES + n / 2)];
            // High nibble first
            code = (n % 2 == 0) ? int'(b[7:4]) : int'(b[3:0]);
            m    = code % 8;
            acc  = (code >= 8) ? acc - step * m : acc + step * m;
            if (acc > 2047) begin
                acc = 2047;
            end
            if (acc < -2048) begin
                acc = -2048;
            end
            if (m >= 6) begin
                step = (step * 2 > `SND_STEP_MAX) ? `SND_STEP_MAX : step * 2;
            end else if (m <= 1) begin
                step = (step > 1) ? step / 2 : 1;
            end
        end
        return acc;
    endfunction

    // Compare process, mid-cycle where outputs are stable
    always @(negedge clk) begin
        if (arst_n && sample) begin
            pulse_cnt++;
            if (exp_q.size() > 0) begin
                check_value($sformatf("pcm sample %0d", pulse_cnt - pulse_base),
                            exp_q.pop_front(), int'(pcm));
            end
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT) begin
            $display("ERROR: test %s did not finish within %0d cycles", test_name, TIMEOUT);
            $display("** FAIL **");
            $finish;
        end
    end

    // Latch write, then the new phrase's expected samples
    task automatic start_command(input snd_cmd_t cmd);
        int i;
        @(posedge clk);
        #1;
        snd_latch    = cmd;
        snd_latch_wr = 1'b1;
        @(posedge clk);
        #1;
        snd_latch_wr = 1'b0;
        // Flush done, older pulses belong to the previous phrase
        exp_q.delete();
        pulse_base = pulse_cnt;
        if (cmd != '0) begin
            for (i = 0; i < PHRASE_LEN; i++) begin
                exp_q.push_back(ref_decode(int'(cmd), i));
            end
        end
    endtask

    task automatic wait_pulses(input int n);
        while (pulse_cnt - pulse_base < n) begin
            @(posedge clk);
        end
    endtask

    task automatic begin_test(input string name);
        test_name     = name;
        errs_at_start = errors;
    endtask

    task automatic end_test();
        if (errors == errs_at_start) begin
            $display("test %-20s passed", test_name);
        end else begin
            failed_tests++;
            $display("test %-20s failed, %0d errors", test_name, errors - errs_at_start);
        end
    endtask

    initial begin
        int       seed;
        int       a;
        int       idle_pulses;
        int       idle_cs;
        snd_cmd_t phrase_a;
        snd_cmd_t phrase_b;
        arst_n       = 1'b0;
        snd_latch    = '0;
        snd_latch_wr = 1'b0;
        rom_slow     = 1'b0;
        seed         = $urandom(74843);
        // Random ROM image, then two saturation phrases
        for (a = 0; a < (1 << IMG_AW); a++) begin
            i_rom.mem[IMG_AW'(a)] = rom_byte_t'($urandom);
        end
        for (a = 0; a < PHRASE_BYTES; a++) begin
            i_rom.mem[IMG_AW'(3 * PHRASE_BYTES + a)] = 8'h77;
            i_rom.mem[IMG_AW'(4 * PHRASE_BYTES + a)] = 8'hff;
        end
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;

        begin_test("reset_idle");
        idle_pulses = 0;
        idle_cs     = 0;
        check_value("pcm after reset", 0, int'(pcm));
        repeat (SETTLE) begin
            @(negedge clk);
            idle_pulses += int'(sample);
            idle_cs     += int'(rom_req.cs);
        end
        check_value("sample pulses", 0, idle_pulses);
        check_value("cycles with cs high", 0, idle_cs);
        end_test();

        begin_test("random_phrase");
        phrase_a = snd_cmd_t'($urandom_range(255, 8));
        start_command(phrase_a);
        wait_pulses(PHRASE_LEN);
        repeat (SETTLE) @(posedge clk);
        check_value("sample pulses", PHRASE_LEN, pulse_cnt - pulse_base);
        end_test();

        begin_test("saturation");
        start_command(8'd3);
        wait_pulses(PHRASE_LEN);
        repeat (SETTLE) @(posedge clk);
        check_value("positive limit", 2047, int'(pcm));
        start_command(8'd4);
        wait_pulses(PHRASE_LEN);
        repeat (SETTLE) @(posedge clk);
        check_value("negative limit", -2048, int'(pcm));
        check_value("sample pulses", PHRASE_LEN, pulse_cnt - pulse_base);
        end_test();

        begin_test("stop_mid_phrase");
        start_command(snd_cmd_t'($urandom_range(255, 8)));
        wait_pulses(10);
        start_command('0);
        check_value("pcm after stop", 0, int'(pcm));
        repeat (2 * SETTLE) @(posedge clk);
        check_value("pulses after stop", 0, pulse_cnt - pulse_base);
        check_value("cs after stop", 0, int'(rom_req.cs));
        end_test();

        begin_test("restart");
        phrase_a = snd_cmd_t'($urandom_range(255, 8));
        phrase_b = snd_cmd_t'($urandom_range(255, 8));
        if (phrase_b == phrase_a) begin
            phrase_b = phrase_a ^ 8'h01;
        end
        start_command(phrase_a);
        wait_pulses(5);
        start_command(phrase_b);
        wait_pulses(PHRASE_LEN);
        repeat (SETTLE) @(posedge clk);
        check_value("sample pulses", PHRASE_LEN, pulse_cnt - pulse_base);
        end_test();

        // ROM slower than the output rate, the FIFO runs dry
        begin_test("slow_rom_underrun");
        @(posedge clk);
        #1;
        rom_slow = 1'b1;
        start_command(snd_cmd_t'($urandom_range(255, 8)));
        wait_pulses(PHRASE_LEN);
        repeat (SETTLE) @(posedge clk);
        check_value("sample pulses", PHRASE_LEN, pulse_cnt - pulse_base);
        end_test();

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+hdl
hdl/snd_audio_pkg.sv
hdl/snd_rom_pkg.sv
hdl/adpcm_fetch.sv
hdl/pcm_fifo.sv
hdl/pcm_out.sv
hdl/snd_adpcm_top.sv
verif/snd_rom_model.sv
verif/tb_snd_adpcm.sv

// File: Makefile
# Verilator build and run of the ADPCM playback testbench
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_snd_adpcm
FILELIST  = tb.f
OBJ_DIR   = obj_dir
PASS_MSG  = ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
